// ==== logic/uarch_pkg.sv ====
// Microarchitecture package for the out-of-order issue back end
// Sizes, typed widths, opcode fields and micro-op encoding

package uarch_pkg;

  // ---------------------------------------------------------------------
  // Sizes
  // ---------------------------------------------------------------------
  localparam int NUM_PIPES   = 3;
  localparam int NUM_AREGS   = 32;
  localparam int NUM_PREGS   = 48;
  localparam int NUM_FREE    = NUM_PREGS - NUM_AREGS;
  localparam int MUL_LATENCY = 3;

  // ---------------------------------------------------------------------
  // Widths
  // ---------------------------------------------------------------------
  typedef logic [31:0]                          word_t;
  typedef logic [4:0]                           arch_reg_t;
  typedef logic [$clog2(NUM_PREGS)-1:0]         preg_t;
  typedef logic [4:0]                           seq_num_t;
  typedef logic [NUM_PIPES-1:0]                 pipe_mask_t;
  typedef logic [$clog2(NUM_PIPES)-1:0]         pipe_idx_t;
  typedef logic [$clog2(NUM_FREE)-1:0]          free_ptr_t;
  typedef logic [$clog2(NUM_FREE+1)-1:0]        free_cnt_t;
  typedef logic [$clog2(MUL_LATENCY+1)-1:0]     lat_t;

  // Micro-ops of the supported subset
  typedef enum logic [1:0] {
    UOP_ADD,
    UOP_ADDI,
    UOP_MUL
  } uop_e;

  // Instruction encoding fields
  localparam logic [6:0] OPC_OP        = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM    = 7'b0010011;
  localparam logic [6:0] FUNCT7_MULDIV = 7'b0000001;

endpackage

// ==== logic/msg_pkg.sv ====
// Message package for the issue back end
// Packed structs carried on the fetch, issue and completion paths

package msg_pkg;

  // Fetch to decode
  typedef struct packed {
    uarch_pkg::word_t    inst;
    uarch_pkg::word_t    pc;
    uarch_pkg::seq_num_t seq_num;
  } fetch_msg_t;

  // Decode to execute pipe
  typedef struct packed {
    uarch_pkg::word_t     pc;
    uarch_pkg::seq_num_t  seq_num;
    uarch_pkg::uop_e      uop;
    uarch_pkg::word_t     op1;
    uarch_pkg::word_t     op2;
    uarch_pkg::arch_reg_t waddr;
    uarch_pkg::preg_t     preg;
    uarch_pkg::preg_t     ppreg;
    logic                 wen;
  } issue_msg_t;

  // Completion notification, also used for pipe results
  typedef struct packed {
    uarch_pkg::seq_num_t  seq_num;
    uarch_pkg::arch_reg_t waddr;
    uarch_pkg::word_t     wdata;
    logic                 wen;
    uarch_pkg::preg_t     preg;
  } complete_msg_t;

endpackage

// ==== logic/rename_table.sv ====
// Register rename table
// Architectural to physical map plus a circular free list of physical
// registers; allocation pops the head, release pushes at the tail

`timescale 1ns/1ps

module rename_table (
  input  logic                 clk,
  input  logic                 rst,
  input  uarch_pkg::arch_reg_t rs1,
  input  uarch_pkg::arch_reg_t rs2,
  input  uarch_pkg::arch_reg_t rd,
  input  logic                 rename_en,
  output uarch_pkg::preg_t     prs1,
  output uarch_pkg::preg_t     prs2,
  output uarch_pkg::preg_t     prd_old,
  output uarch_pkg::preg_t     prd_new,
  output logic                 free_avail,
  input  logic                 free_en,
  input  uarch_pkg::preg_t     free_preg
);

  uarch_pkg::preg_t     map_q  [uarch_pkg::NUM_AREGS];
  uarch_pkg::preg_t     free_q [uarch_pkg::NUM_FREE];
  uarch_pkg::free_ptr_t head_q;
  uarch_pkg::free_ptr_t tail_q;
  uarch_pkg::free_cnt_t count_q;

  function automatic uarch_pkg::free_ptr_t next_ptr(input uarch_pkg::free_ptr_t ptr);
    if (ptr == uarch_pkg::free_ptr_t'(uarch_pkg::NUM_FREE - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  // Lookups are combinational so that sources see the map before this rename
  assign prs1       = map_q[rs1];
  assign prs2       = map_q[rs2];
  assign prd_old    = map_q[rd];
  assign prd_new    = free_q[head_q];
  assign free_avail = (count_q != '0);

  // ----------------------------------------------------------------------
  // Map table and free list update
  // ----------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      // Identity map, upper registers all free
      for (int i = 0; i < uarch_pkg::NUM_AREGS; i++) begin
        map_q[i] <= uarch_pkg::preg_t'(i);
      end
      for (int j = 0; j < uarch_pkg::NUM_FREE; j++) begin
        free_q[j] <= uarch_pkg::preg_t'(uarch_pkg::NUM_AREGS + j);
      end
      head_q  <= '0;
      tail_q  <= '0;
      count_q <= uarch_pkg::free_cnt_t'(uarch_pkg::NUM_FREE);
    end else begin
      if (rename_en) begin
        map_q[rd] <= free_q[head_q];
        head_q    <= next_ptr(head_q);
      end
      if (free_en) begin
        free_q[tail_q] <= free_preg;
        tail_q         <= next_ptr(tail_q);
      end
      // Pop and push in one cycle leave the count alone
      if (rename_en && !free_en) begin
        count_q <= count_q - 1'b1;
      end else if (!rename_en && free_en) begin
        count_q <= count_q + 1'b1;
      end
    end
  end

endmodule

// ==== logic/phys_regfile.sv ====
// Physical register file
// Values with a ready bit per register; two value read ports, one
// ready-only check port, one write port that also sets ready

`timescale 1ns/1ps

module phys_regfile (
  input  logic             clk,
  input  logic             rst,
  input  uarch_pkg::preg_t raddr1,
  input  uarch_pkg::preg_t raddr2,
  input  uarch_pkg::preg_t raddr3,
  output uarch_pkg::word_t rdata1,
  output uarch_pkg::word_t rdata2,
  output logic             rrdy1,
  output logic             rrdy2,
  output logic             rrdy3,
  input  logic             clr_en,
  input  uarch_pkg::preg_t clr_preg,
  input  logic             wb_en,
  input  uarch_pkg::preg_t wb_preg,
  input  uarch_pkg::word_t wb_data
);

  uarch_pkg::word_t              val_q [uarch_pkg::NUM_PREGS];
  logic [uarch_pkg::NUM_PREGS-1:0] rdy_q;

  assign rdata1 = val_q[raddr1];
  assign rdata2 = val_q[raddr2];
  assign rrdy1  = rdy_q[raddr1];
  assign rrdy2  = rdy_q[raddr2];
  // Third port only checks that the previous mapping of rd has been written
  assign rrdy3  = rdy_q[raddr3];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < uarch_pkg::NUM_PREGS; i++) begin
        val_q[i] <= '0;
      end
      rdy_q <= '1;
    end else begin
      // Fresh allocation waits for its producer
      if (clr_en) begin
        rdy_q[clr_preg] <= 1'b0;
      end
      if (wb_en) begin
        val_q[wb_preg] <= wb_data;
        rdy_q[wb_preg] <= 1'b1;
      end
    end
  end

endmodule

// ==== logic/decode_issue_unit.sv ====
// Decode and issue unit
// Holds one fetched instruction, decodes ADD/ADDI/MUL, reads operands,
// renames the destination and steers to the lowest-index idle pipe

`timescale 1ns/1ps

module decode_issue_unit (
  input  logic                  clk,
  input  logic                  rst,
  // Fetch handshake
  input  msg_pkg::fetch_msg_t   fetch_msg,
  input  logic                  fetch_val,
  output logic                  fetch_rdy,
  // Issue to the pipes
  output msg_pkg::issue_msg_t   issue_msg,
  output uarch_pkg::pipe_mask_t issue_val,
  input  uarch_pkg::pipe_mask_t issue_rdy,
  // Rename table
  output uarch_pkg::arch_reg_t  rs1,
  output uarch_pkg::arch_reg_t  rs2,
  output uarch_pkg::arch_reg_t  rd,
  output logic                  rename_en,
  input  uarch_pkg::preg_t      prs1,
  input  uarch_pkg::preg_t      prs2,
  input  uarch_pkg::preg_t      prd_old,
  input  uarch_pkg::preg_t      prd_new,
  input  logic                  free_avail,
  // Register file
  output uarch_pkg::preg_t      raddr1,
  output uarch_pkg::preg_t      raddr2,
  output uarch_pkg::preg_t      raddr3,
  input  uarch_pkg::word_t      rdata1,
  input  uarch_pkg::word_t      rdata2,
  input  logic                  rrdy1,
  input  logic                  rrdy2,
  input  logic                  rrdy3,
  output logic                  clr_en,
  output uarch_pkg::preg_t      clr_preg
);

  logic                 dec_val_q;
  msg_pkg::fetch_msg_t  dec_msg_q;
  uarch_pkg::uop_e      uop;
  uarch_pkg::word_t     imm;
  logic [6:0]           opcode;
  logic [6:0]           funct7;
  logic                 renames;
  logic                 src_ok;
  logic                 dst_ok;
  logic                 issue_fire;
  uarch_pkg::pipe_mask_t pick;

  // ----------------------------------------------------------------------
  // Decode register
  // ----------------------------------------------------------------------
  assign fetch_rdy = !dec_val_q || issue_fire;

  always_ff @(posedge clk) begin
    if (rst) begin
      dec_val_q <= 1'b0;
    end else if (fetch_val && fetch_rdy) begin
      dec_val_q <= 1'b1;
    end else if (issue_fire) begin
      dec_val_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (fetch_val && fetch_rdy) begin
      dec_msg_q <= fetch_msg;
    end
  end

  // ----------------------------------------------------------------------
  // Decoder
  // ----------------------------------------------------------------------
  assign opcode = dec_msg_q.inst[6:0];
  assign funct7 = dec_msg_q.inst[31:25];
  assign rd     = dec_msg_q.inst[11:7];
  assign rs1    = dec_msg_q.inst[19:15];
  assign rs2    = dec_msg_q.inst[24:20];
  assign imm    = {{20{dec_msg_q.inst[31]}}, dec_msg_q.inst[31:20]};

  always_comb begin
    if (opcode == uarch_pkg::OPC_OP_IMM) begin
      uop = uarch_pkg::UOP_ADDI;
    end else if (opcode == uarch_pkg::OPC_OP && funct7 == uarch_pkg::FUNCT7_MULDIV) begin
      uop = uarch_pkg::UOP_MUL;
    end else begin
      uop = uarch_pkg::UOP_ADD;
    end
  end

  // x0 keeps its fixed mapping
  assign renames = (rd != '0);

  // ----------------------------------------------------------------------
  // Stall and steering
  // ----------------------------------------------------------------------
  assign raddr1 = prs1;
  assign raddr2 = prs2;
  assign raddr3 = prd_old;

  // rs2 field of ADDI is immediate bits
  assign src_ok = rrdy1 && (uop == uarch_pkg::UOP_ADDI || rrdy2);
  // Previous writer of rd must be done before its register may be freed
  assign dst_ok = !renames || (free_avail && rrdy3);

  assign issue_fire = dec_val_q && src_ok && dst_ok && (issue_rdy != '0);

  // Lowest set bit of the idle mask
  assign pick      = issue_rdy & uarch_pkg::pipe_mask_t'(~issue_rdy + 1'b1);
  assign issue_val = issue_fire ? pick : '0;

  assign rename_en = issue_fire && renames;
  assign clr_en    = rename_en;
  assign clr_preg  = prd_new;

  always_comb begin
    issue_msg.pc      = dec_msg_q.pc;
    issue_msg.seq_num = dec_msg_q.seq_num;
    issue_msg.uop     = uop;
    issue_msg.op1     = rdata1;
    issue_msg.op2     = (uop == uarch_pkg::UOP_ADDI) ? imm : rdata2;
    issue_msg.waddr   = rd;
    issue_msg.preg    = renames ? prd_new : prd_old;
    issue_msg.ppreg   = prd_old;
    issue_msg.wen     = renames;
  end

endmodule

// ==== logic/exec_pipe.sv ====
// Execute pipe
// Holds one operation, computes its result on entry and presents it
// after the op latency until the writeback arbiter acks it

`timescale 1ns/1ps

module exec_pipe (
  input  logic                   clk,
  input  logic                   rst,
  input  msg_pkg::issue_msg_t    issue_msg,
  input  logic                   issue_val,
  output logic                   issue_rdy,
  output logic                   res_val,
  output msg_pkg::complete_msg_t res_msg,
  output uarch_pkg::preg_t       res_ppreg,
  input  logic                   res_ack
);

  logic            busy_q;
  uarch_pkg::lat_t cnt_q;
  uarch_pkg::lat_t lat;
  uarch_pkg::word_t result;

  assign issue_rdy = !busy_q;
  assign res_val   = busy_q && (cnt_q == '0);

  assign lat = (issue_msg.uop == uarch_pkg::UOP_MUL) ?
               uarch_pkg::lat_t'(uarch_pkg::MUL_LATENCY) : uarch_pkg::lat_t'(1);

  // Low 32 bits of the product for MUL
  assign result = (issue_msg.uop == uarch_pkg::UOP_MUL) ?
                  issue_msg.op1 * issue_msg.op2 : issue_msg.op1 + issue_msg.op2;

  always_ff @(posedge clk) begin
    if (rst) begin
      busy_q <= 1'b0;
      cnt_q  <= '0;
    end else if (issue_val && issue_rdy) begin
      busy_q <= 1'b1;
      cnt_q  <= lat;
    end else if (busy_q && cnt_q != '0) begin
      cnt_q <= cnt_q - 1'b1;
    end else if (res_val && res_ack) begin
      busy_q <= 1'b0;
    end
  end

  // Result payload
  always_ff @(posedge clk) begin
    if (issue_val && issue_rdy) begin
      res_msg.seq_num <= issue_msg.seq_num;
      res_msg.waddr   <= issue_msg.waddr;
      res_msg.wdata   <= result;
      res_msg.wen     <= issue_msg.wen;
      res_msg.preg    <= issue_msg.preg;
      res_ppreg       <= issue_msg.ppreg;
    end
  end

endmodule

// ==== logic/writeback_arbiter.sv ====
// Writeback arbiter
// Round-robin pick of one finished pipe per cycle; writes the register
// file, releases the old register and registers the completion pulse

`timescale 1ns/1ps

module writeback_arbiter (
  input  logic                   clk,
  input  logic                   rst,
  input  uarch_pkg::pipe_mask_t  res_val,
  input  msg_pkg::complete_msg_t res_msg   [uarch_pkg::NUM_PIPES],
  input  uarch_pkg::preg_t       res_ppreg [uarch_pkg::NUM_PIPES],
  output uarch_pkg::pipe_mask_t  res_ack,
  output logic                   wb_en,
  output uarch_pkg::preg_t       wb_preg,
  output uarch_pkg::word_t       wb_data,
  output logic                   free_en,
  output uarch_pkg::preg_t       free_preg,
  output logic                   complete_val,
  output msg_pkg::complete_msg_t complete_msg
);

  uarch_pkg::pipe_idx_t   last_q;
  uarch_pkg::pipe_idx_t   grant_idx;
  logic                   found;
  msg_pkg::complete_msg_t sel_msg;

  // Search starts one past the last grant
  always_comb begin
    int idx;
    found     = 1'b0;
    grant_idx = last_q;
    for (int i = 1; i <= uarch_pkg::NUM_PIPES; i++) begin
      idx = (int'(last_q) + i) % uarch_pkg::NUM_PIPES;
      if (!found && res_val[idx]) begin
        found     = 1'b1;
        grant_idx = uarch_pkg::pipe_idx_t'(idx);
      end
    end
  end

  always_comb begin
    res_ack = '0;
    if (found) begin
      res_ack[grant_idx] = 1'b1;
    end
  end

  assign sel_msg   = res_msg[grant_idx];
  assign wb_en     = found && sel_msg.wen;
  assign wb_preg   = sel_msg.preg;
  assign wb_data   = sel_msg.wdata;
  assign free_en   = wb_en;
  assign free_preg = res_ppreg[grant_idx];

  always_ff @(posedge clk) begin
    if (rst) begin
      complete_val <= 1'b0;
      last_q       <= uarch_pkg::pipe_idx_t'(uarch_pkg::NUM_PIPES - 1);
    end else begin
      complete_val <= found;
      if (found) begin
        last_q <= grant_idx;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (found) begin
      complete_msg <= sel_msg;
    end
  end

endmodule

// ==== logic/issue_backend_top.sv ====
// Issue back end top level
// Decode-issue unit with rename table and register file, a row of
// identical execute pipes and the writeback arbiter

`timescale 1ns/1ps

module issue_backend_top (
  input  logic                   clk,
  input  logic                   rst,
  input  msg_pkg::fetch_msg_t    fetch_msg,
  input  logic                   fetch_val,
  output logic                   fetch_rdy,
  output logic                   complete_val,
  output msg_pkg::complete_msg_t complete_msg
);

  uarch_pkg::arch_reg_t   rs1, rs2, rd;
  uarch_pkg::preg_t       prs1, prs2, prd_old, prd_new;
  logic                   rename_en, free_avail;
  uarch_pkg::preg_t       raddr1, raddr2, raddr3;
  uarch_pkg::word_t       rdata1, rdata2;
  logic                   rrdy1, rrdy2, rrdy3;
  logic                   clr_en;
  uarch_pkg::preg_t       clr_preg;
  logic                   wb_en, free_en;
  uarch_pkg::preg_t       wb_preg, free_preg;
  uarch_pkg::word_t       wb_data;
  msg_pkg::issue_msg_t    issue_msg;
  uarch_pkg::pipe_mask_t  issue_val, issue_rdy, res_val, res_ack;
  msg_pkg::complete_msg_t res_msg   [uarch_pkg::NUM_PIPES];
  uarch_pkg::preg_t       res_ppreg [uarch_pkg::NUM_PIPES];

  rename_table i_rename_table (
    .clk, .rst, .rs1, .rs2, .rd, .rename_en, .prs1, .prs2, .prd_old, .prd_new,
    .free_avail, .free_en, .free_preg
  );

  phys_regfile i_phys_regfile (
    .clk, .rst, .raddr1, .raddr2, .raddr3, .rdata1, .rdata2, .rrdy1, .rrdy2,
    .rrdy3, .clr_en, .clr_preg, .wb_en, .wb_preg, .wb_data
  );

  decode_issue_unit i_decode_issue_unit (
    .clk, .rst, .fetch_msg, .fetch_val, .fetch_rdy, .issue_msg, .issue_val,
    .issue_rdy, .rs1, .rs2, .rd, .rename_en, .prs1, .prs2, .prd_old, .prd_new,
    .free_avail, .raddr1, .raddr2, .raddr3, .rdata1, .rdata2, .rrdy1, .rrdy2,
    .rrdy3, .clr_en, .clr_preg
  );

  // Identical execute pipes sharing the issue bus
  for (genvar k = 0; k < uarch_pkg::NUM_PIPES; k++) begin : g_pipe
    exec_pipe i_exec_pipe (
      .clk       (clk),
      .rst       (rst),
      .issue_msg (issue_msg),
      .issue_val (issue_val[k]),
      .issue_rdy (issue_rdy[k]),
      .res_val   (res_val[k]),
      .res_msg   (res_msg[k]),
      .res_ppreg (res_ppreg[k]),
      .res_ack   (res_ack[k])
    );
  end

  writeback_arbiter i_writeback_arbiter (
    .clk, .rst, .res_val, .res_msg, .res_ppreg, .res_ack, .wb_en, .wb_preg,
    .wb_data, .free_en, .free_preg, .complete_val, .complete_msg
  );

endmodule

// ==== verification/completion_checker.sv ====
// Completion checker for the issue back end
// Records the expected result of every fetched instruction by sequence
// number and compares it with the completion notifications

`timescale 1ns/1ps

module completion_checker (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   fetch_val,
  input  logic                   fetch_rdy,
  input  msg_pkg::complete_msg_t expect_msg,
  input  logic                   complete_val,
  input  msg_pkg::complete_msg_t complete_msg,
  output int                     pending,
  output int                     checked,
  output int                     overtakes,
  output int                     errors
);

  localparam int NUM_SEQ = 2 ** $bits(uarch_pkg::seq_num_t);

  msg_pkg::complete_msg_t expect_q [NUM_SEQ];
  logic [NUM_SEQ-1:0]     busy_q;
  uarch_pkg::seq_num_t    last_seq_q;

  // Rename model over free-list pops in program order
  // Negative map entries stand for the identity mapping of reset
  uarch_pkg::preg_t       free_order [$];
  int                     map_m  [uarch_pkg::NUM_AREGS];
  int                     dst_q  [NUM_SEQ];
  int                     prev_q [NUM_SEQ];
  int                     allocs;

  // Physical register behind a map entry, or -1 while not yet released
  function automatic int resolve(input int entry);
    int preg;
    preg = -1;
    if (entry < 0) begin
      preg = -entry - 1;
    end else if (entry < free_order.size()) begin
      preg = int'(free_order[entry]);
    end
    return preg;
  endfunction

  // One completion against its stored expectation
  task automatic compare(input msg_pkg::complete_msg_t got);
    msg_pkg::complete_msg_t want;
    int                     want_preg;
    want      = expect_q[got.seq_num];
    want_preg = resolve(dst_q[got.seq_num]);
    checked++;
    if (got.wen !== want.wen) begin
      $display("Mismatch at %0t: seq %0d wen got %b expected %b",
               $time, got.seq_num, got.wen, want.wen);
      errors++;
    end
    if (got.waddr !== want.waddr) begin
      $display("Mismatch at %0t: seq %0d waddr got x%0d expected x%0d",
               $time, got.seq_num, got.waddr, want.waddr);
      errors++;
    end
    // Data only counts when a register is written
    if (want.wen && got.wdata !== want.wdata) begin
      $display("Mismatch at %0t: seq %0d wdata got %h expected %h",
               $time, got.seq_num, got.wdata, want.wdata);
      errors++;
    end
    if (want_preg < 0) begin
      $display("Completion of seq %0d at %0t came before its register could be freed",
               got.seq_num, $time);
      errors++;
    end else if (got.preg !== uarch_pkg::preg_t'(want_preg)) begin
      $display("Mismatch at %0t: seq %0d preg got p%0d expected p%0d",
               $time, got.seq_num, got.preg, want_preg);
      errors++;
    end
  endtask

  // ----------------------------------------------------------------------
  // Completions first, then new expectations from fetch transfers
  // ----------------------------------------------------------------------
  always @(posedge clk) begin
    if (rst) begin
      busy_q     = '0;
      pending    = 0;
      checked    = 0;
      overtakes  = 0;
      errors     = 0;
      last_seq_q = '1;
      allocs     = 0;
      free_order.delete();
      for (int j = 0; j < uarch_pkg::NUM_FREE; j++) begin
        free_order.push_back(uarch_pkg::preg_t'(uarch_pkg::NUM_AREGS + j));
      end
      for (int i = 0; i < uarch_pkg::NUM_AREGS; i++) begin
        map_m[i] = -i - 1;
      end
    end else begin
      if (complete_val) begin
        if (!busy_q[complete_msg.seq_num]) begin
          $display("Unexpected completion at %0t: seq %0d was not outstanding",
                   $time, complete_msg.seq_num);
          errors++;
        end else begin
          compare(complete_msg);
          if (complete_msg.seq_num != uarch_pkg::seq_num_t'(last_seq_q + 1'b1)) begin
            overtakes++;
          end
          last_seq_q = complete_msg.seq_num;
          // The old register goes back on the free list
          if (expect_q[complete_msg.seq_num].wen) begin
            free_order.push_back(
              uarch_pkg::preg_t'(resolve(prev_q[complete_msg.seq_num])));
          end
          busy_q[complete_msg.seq_num] = 1'b0;
          pending--;
        end
      end
      if (fetch_val && fetch_rdy) begin
        if (busy_q[expect_msg.seq_num]) begin
          $display("Sequence number %0d reused at %0t while still outstanding",
                   expect_msg.seq_num, $time);
          errors++;
        end else begin
          pending++;
        end
        expect_q[expect_msg.seq_num] = expect_msg;
        busy_q[expect_msg.seq_num]   = 1'b1;
        prev_q[expect_msg.seq_num]   = map_m[expect_msg.waddr];
        // x0 keeps its reset mapping
        if (expect_msg.wen) begin
          map_m[expect_msg.waddr] = allocs;
          allocs++;
        end
        dst_q[expect_msg.seq_num] = map_m[expect_msg.waddr];
      end
    end
  end

endmodule

// ==== verification/issue_backend_tb.sv ====
// Testbench for the issue back end
// Builds ADD/ADDI/MUL programs, runs each through an architectural
// reference model and streams it into the DUT over the fetch handshake

`timescale 1ns/1ps

module issue_backend_tb;

  localparam int RDY_TIMEOUT   = 200;
  localparam int DRAIN_TIMEOUT = 1000;

  logic                   clk;
  logic                   rst;
  msg_pkg::fetch_msg_t    fetch_msg;
  logic                   fetch_val;
  logic                   fetch_rdy;
  logic                   complete_val;
  msg_pkg::complete_msg_t complete_msg;
  msg_pkg::complete_msg_t expect_msg;
  int                     pending;
  int                     checked;
  int                     overtakes;
  int                     errors;

  uarch_pkg::word_t    arch_q [32];
  logic [31:0]         lfsr_q;
  uarch_pkg::seq_num_t seq_q;
  uarch_pkg::word_t    pc_q;
  logic                hung;
  int                  tb_errors;
  int                  tests;
  int                  last_checked;
  int                  last_errors;
  int                  last_overtakes;

  issue_backend_top i_issue_backend_top (
    .clk, .rst, .fetch_msg, .fetch_val, .fetch_rdy, .complete_val, .complete_msg
  );

  completion_checker i_completion_checker (
    .clk, .rst, .fetch_val, .fetch_rdy, .expect_msg, .complete_val, .complete_msg,
    .pending, .checked, .overtakes, .errors
  );

  always #4 clk = ~clk;

  // ----------------------------------------------------------------------
  // Random bits, instruction encoding and reference model
  // ----------------------------------------------------------------------
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v      = {v[30:0], lfsr_q[0]};
      lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'h80200003) : (lfsr_q >> 1);
    end
    return v;
  endfunction

  function automatic uarch_pkg::word_t enc_op(input logic [6:0] f7, input int rd,
                                              input int rs1, input int rs2);
    return {f7, rs2[4:0], rs1[4:0], 3'b000, rd[4:0], uarch_pkg::OPC_OP};
  endfunction

  function automatic uarch_pkg::word_t enc_addi(input int rd, input int rs1, input int imm);
    return {imm[11:0], rs1[4:0], 3'b000, rd[4:0], uarch_pkg::OPC_OP_IMM};
  endfunction

  // Executes in program order; x0 is never written
  function automatic msg_pkg::complete_msg_t ref_exec(input uarch_pkg::word_t inst,
                                                      input uarch_pkg::seq_num_t seq);
    msg_pkg::complete_msg_t r;
    uarch_pkg::word_t       a;
    uarch_pkg::word_t       b;
    a = arch_q[inst[19:15]];
    b = arch_q[inst[24:20]];
    if (inst[6:0] == uarch_pkg::OPC_OP_IMM) begin
      b = {{20{inst[31]}}, inst[31:20]};
    end
    r.seq_num = seq;
    r.waddr   = inst[11:7];
    r.wen     = (inst[11:7] != 5'd0);
    r.preg    = '0;
    if (inst[6:0] == uarch_pkg::OPC_OP && inst[31:25] == uarch_pkg::FUNCT7_MULDIV) begin
      r.wdata = a * b;
    end else begin
      r.wdata = a + b;
    end
    if (r.wen) begin
      arch_q[r.waddr] = r.wdata;
    end
    return r;
  endfunction

  // ----------------------------------------------------------------------
  // Stimulus tasks are entered and left right after a rising edge
  // ----------------------------------------------------------------------
  task automatic send(input uarch_pkg::word_t inst);
    int waited;
    waited = 0;
    if (!hung) begin
      fetch_msg.inst    <= inst;
      fetch_msg.pc      <= pc_q;
      fetch_msg.seq_num <= seq_q;
      fetch_val         <= 1'b1;
      expect_msg        <= ref_exec(inst, seq_q);
      @(negedge clk);
      while (!fetch_rdy && waited < RDY_TIMEOUT) begin
        waited++;
        @(negedge clk);
      end
      if (!fetch_rdy) begin
        $display("Timeout: fetch_rdy stayed low for %0d cycles at seq %0d", waited, seq_q);
        hung = 1'b1;
      end else begin
        @(posedge clk);
        pc_q  = pc_q + 32'd4;
        seq_q = seq_q + 1'b1;
      end
    end
  endtask

  task automatic idle_check(input int cycles);
    repeat (cycles) begin
      @(negedge clk);
      if (!fetch_rdy || complete_val) begin
        $display("Mismatch at %0t: idle DUT shows fetch_rdy %b complete_val %b",
                 $time, fetch_rdy, complete_val);
        tb_errors++;
      end
    end
    @(posedge clk);
  endtask

  // Waits for every outstanding completion, then reports the test
  task automatic finish_test(input string name, input logic want_overtake);
    int waited;
    waited = 0;
    fetch_val <= 1'b0;
    if (!hung) begin
      @(negedge clk);
      while (pending != 0 && waited < DRAIN_TIMEOUT) begin
        waited++;
        @(negedge clk);
      end
      if (pending != 0) begin
        $display("Hang: %0d completions still outstanding after %0d cycles in test %s",
                 pending, waited, name);
        hung = 1'b1;
      end else begin
        // Out-of-order traffic has to show at least one overtaking completion
        if (want_overtake && overtakes == last_overtakes) begin
          $display("No completion overtook an older one in test %s", name);
          tb_errors++;
        end
        tests++;
        $display("Test %s: %0d completions checked, %0d errors",
                 name, checked - last_checked, errors + tb_errors - last_errors);
        last_checked   = checked;
        last_errors    = errors + tb_errors;
        last_overtakes = overtakes;
        @(posedge clk);
      end
    end
  endtask

  task automatic run_random(input int count);
    logic [31:0] kind;
    int          rd;
    int          rs1;
    int          rs2;
    int          imm;
    for (int i = 0; i < count; i++) begin
      kind = take_bits(2) % 3;
      // Only x0 to x7 so that dependences are frequent
      rd   = int'(take_bits(3));
      rs1  = int'(take_bits(3));
      rs2  = int'(take_bits(3));
      imm  = int'(take_bits(12));
      if (kind == 0) begin
        send(enc_op(7'b0, rd, rs1, rs2));
      end else if (kind == 1) begin
        send(enc_addi(rd, rs1, imm));
      end else begin
        send(enc_op(uarch_pkg::FUNCT7_MULDIV, rd, rs1, rs2));
      end
    end
  endtask

  // ----------------------------------------------------------------------
  // Test sequence
  // ----------------------------------------------------------------------
  initial begin
    clk            = 1'b0;
    rst            = 1'b1;
    fetch_val      = 1'b0;
    fetch_msg      = '0;
    expect_msg     = '0;
    lfsr_q         = 32'd85588;
    seq_q          = '0;
    pc_q           = '0;
    hung           = 1'b0;
    tb_errors      = 0;
    tests          = 0;
    last_checked   = 0;
    last_errors    = 0;
    last_overtakes = 0;
    for (int i = 0; i < 32; i++) begin
      arch_q[i] = '0;
    end
    repeat (16) @(posedge clk);
    rst <= 1'b0;

    idle_check(20);
    send(enc_addi(1, 0, 5));
    send(enc_addi(2, 0, -300));
    send(enc_addi(4, 0, 2047));
    send(enc_op(7'b0, 3, 0, 0));
    send(enc_op(7'b0, 5, 6, 7));
    finish_test("reset_and_independent", 1'b0);

    // ADDI feeds MUL feeds ADD
    send(enc_addi(6, 0, 7));
    send(enc_op(uarch_pkg::FUNCT7_MULDIV, 7, 6, 6));
    send(enc_op(7'b0, 5, 7, 6));
    send(enc_op(uarch_pkg::FUNCT7_MULDIV, 1, 5, 2));
    send(enc_op(7'b0, 3, 1, 1));
    finish_test("raw_chain", 1'b0);

    for (int i = 1; i <= 40; i++) begin
      send(enc_addi(3, 0, i));
    end
    send(enc_op(7'b0, 4, 3, 3));
    finish_test("waw_recycle", 1'b0);

    send(enc_addi(0, 0, 123));
    send(enc_op(uarch_pkg::FUNCT7_MULDIV, 0, 1, 2));
    send(enc_op(7'b0, 5, 0, 0));
    send(enc_addi(6, 0, 9));
    send(enc_op(7'b0, 7, 0, 6));
    finish_test("x0_writes", 1'b0);

    // Slow MULs overtaken by ADDIs while sequence numbers wrap
    for (int i = 0; i < 48; i++) begin
      if (i % 3 == 0) begin
        send(enc_op(uarch_pkg::FUNCT7_MULDIV, 7, 4, 4));
      end else begin
        send(enc_addi(i % 3 + 1, 0, i));
      end
    end
    finish_test("mixed_out_of_order", 1'b1);

    run_random(300);
    finish_test("random_program", 1'b0);

    @(negedge clk);
    $display("Totals: %0d tests, %0d completions checked, %0d errors",
             tests, checked, errors + tb_errors);
    if (hung || errors + tb_errors != 0) begin
      $display("FAIL: see errors above");
    end else begin
      $display("PASS: all tests");
    end
    $finish;
  end

endmodule

// ==== build.f ====
logic/uarch_pkg.sv
logic/msg_pkg.sv
logic/rename_table.sv
logic/phys_regfile.sv
logic/decode_issue_unit.sv
logic/exec_pipe.sv
logic/writeback_arbiter.sv
logic/issue_backend_top.sv
verification/completion_checker.sv
verification/issue_backend_tb.sv
